/* Bender.yml */
package:
  name: cfg_fabric

sources:
  - include_dirs:
      - logic
    files:
      - logic/cfg_pkg.sv
      - logic/cfg_req_if.sv
      - logic/cfg_req_ctrl.sv
      - logic/cfg_reg_bank.sv
      - logic/cfg_rsp_reduce.sv
      - logic/cfg_fabric_top.sv

  - target: test
    include_dirs:
      - logic
    files:
      - test/cfg_fabric_tb.sv

/* list.f */
+incdir+logic
logic/cfg_pkg.sv
logic/cfg_req_if.sv
logic/cfg_req_ctrl.sv
logic/cfg_reg_bank.sv
logic/cfg_rsp_reduce.sv
logic/cfg_fabric_top.sv
test/cfg_fabric_tb.sv

/* logic/cfg_fabric_top.sv */
// configuration fabric top level, joins request control, register banks and the response reducer
`default_nettype none
`timescale 1ns/1ps

`include "cfg_params.svh"

module cfg_fabric_top (
  input  logic                   clk,
  input  logic                   rst_n,
  // requester side, one strobe per request and no back-pressure
  input  logic                   req_valid,
  input  logic                   req_write,
  input  logic [`CFG_ADDR_W-1:0] req_addr,
  input  logic [`CFG_DATA_W-1:0] req_wdata,
  // response side, ack arrives three cycles after the strobe
  output logic                   rsp_ack,
  output logic                   rsp_err,
  output logic [`CFG_DATA_W-1:0] rsp_rdata
);

  // decoded request bus shared by every target
  cfg_req_if req_bus ();

  // per-target response lanes feeding the reducer
  logic [`CFG_NUM_TGTS-1:0]             bank_ack;
  logic [`CFG_NUM_TGTS-1:0]             bank_err;
  logic [`CFG_NUM_TGTS*`CFG_DATA_W-1:0] bank_rdata;
  logic                                 ctrl_miss;

  cfg_req_ctrl u_ctrl (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_valid (req_valid),
    .req_write (req_write),
    .req_addr  (req_addr),
    .req_wdata (req_wdata),
    .req       (req_bus),
    .miss      (ctrl_miss)
  );

  // one bank per target index, each one tagged with its own id
  for (genvar t = 0; t < `CFG_NUM_TGTS; t++) begin : g_bank
    cfg_reg_bank #(
      .TGT_ID (t)
    ) u_bank (
      .clk   (clk),
      .rst_n (rst_n),
      .req   (req_bus),
      .ack   (bank_ack[t]),
      .err   (bank_err[t]),
      .rdata (bank_rdata[t*`CFG_DATA_W +: `CFG_DATA_W])
    );
  end

  cfg_rsp_reduce #(
    .NUM_TGTS (`CFG_NUM_TGTS)
  ) u_reduce (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_ack   (bank_ack),
    .in_err   (bank_err),
    .in_rdata (bank_rdata),
    .miss     (ctrl_miss),
    .ack      (rsp_ack),
    .err      (rsp_err),
    .rdata    (rsp_rdata)
  );

endmodule : cfg_fabric_top

`default_nettype wire

/* logic/cfg_params.svh */
// configuration fabric parameters for target count, register layout and address fields
`ifndef CFG_PARAMS_SVH
`define CFG_PARAMS_SVH

// number of register-bank targets hanging off the fabric
`define CFG_NUM_TGTS 4

// registers in each target, offset 0 is the read-only identity word
`define CFG_REGS_PER_TGT 8

// register and read data width
`define CFG_DATA_W 32

// request address width and the split between offset and target index
`define CFG_ADDR_W 8
`define CFG_OFF_LSB 0
`define CFG_OFF_MSB 2
`define CFG_TGT_LSB 3
`define CFG_TGT_MSB 7

// upper 24 bits of every identity word, the low byte carries the target id
`define CFG_ID_SIG 24'hc0f1d0

`endif

/* logic/cfg_pkg.sv */
// shared types for the configuration fabric, access opcodes and register offsets
`default_nettype none

`include "cfg_params.svh"

package cfg_pkg;

  // access opcode carried with every decoded request
  typedef enum logic [0:0] {
    CFG_READ  = 1'b0,
    CFG_WRITE = 1'b1
  } cfg_op_e;

  // register offset inside one target
  typedef logic [$clog2(`CFG_REGS_PER_TGT)-1:0] cfg_off_t;

endpackage : cfg_pkg

`default_nettype wire

/* logic/cfg_reg_bank.sv */
// configuration target with a read-only identity word and writable registers
`default_nettype none
`timescale 1ns/1ps

`include "cfg_params.svh"

module cfg_reg_bank #(
  parameter int TGT_ID = 0
) (
  input  logic                   clk,
  input  logic                   rst_n,
  cfg_req_if.target              req,
  output logic                   ack,
  output logic                   err,
  output logic [`CFG_DATA_W-1:0] rdata
);
  import cfg_pkg::*;

  // identity word, signature on top and the target number in the low byte
  localparam logic [`CFG_DATA_W-1:0] ID_WORD = {`CFG_ID_SIG, 8'(TGT_ID)};

  logic [`CFG_DATA_W-1:0] regs [1:`CFG_REGS_PER_TGT-1];
  logic                   sel_me;
  logic                   is_wr;
  logic                   id_off;
  logic                   wr_ok;
  logic                   wr_ro;
  logic [`CFG_DATA_W-1:0] rd_val;

  // this target only reacts to its own bit of the select vector
  assign sel_me = req.sel[TGT_ID];
  assign is_wr  = (req.op == CFG_WRITE);
  assign id_off = (req.off == '0);

  // writes go through everywhere except the identity word
  assign wr_ok = sel_me && is_wr && !id_off;
  // a write aimed at the identity word is refused and reported as an error
  assign wr_ro = sel_me && is_wr && id_off;

  // read mux, offset 0 never touches the register array
  always_comb begin
    if (id_off) begin
      rd_val = ID_WORD;
    end else begin
      rd_val = regs[req.off];
    end
  end

  // writable registers clear on reset and take a write in the sel cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int r = 1; r < `CFG_REGS_PER_TGT; r++) begin
        regs[r] <= '0;
      end
    end else if (wr_ok) begin
      regs[req.off] <= req.wdata;
    end
  end

  // ack is a single cycle pulse one edge after sel, err travels with it
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ack <= 1'b0;
      err <= 1'b0;
    end else begin
      ack <= sel_me;
      err <= wr_ro;
    end
  end

  // read data is captured alongside the ack
  // writes answer with zero data whether or not they were accepted
  always_ff @(posedge clk) begin
    if (sel_me) begin
      rdata <= is_wr ? '0 : rd_val;
    end
  end

endmodule : cfg_reg_bank

`default_nettype wire

/* logic/cfg_req_ctrl.sv */
// request control block, registers and decodes strobed requests and flags address misses
`default_nettype none
`timescale 1ns/1ps

`include "cfg_params.svh"

module cfg_req_ctrl (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   req_valid,
  input  logic                   req_write,
  input  logic [`CFG_ADDR_W-1:0] req_addr,
  input  logic [`CFG_DATA_W-1:0] req_wdata,
  cfg_req_if.ctrl                req,
  output logic                   miss
);
  import cfg_pkg::*;

  localparam int TGT_IDX_W = `CFG_TGT_MSB - `CFG_TGT_LSB + 1;

  logic [TGT_IDX_W-1:0]     tgt_idx;
  logic                     tgt_hit;
  logic [`CFG_NUM_TGTS-1:0] sel_nxt;
  cfg_op_e                  op_nxt;
  cfg_off_t                 off_nxt;
  logic                     miss_q1;

  // split the flat address into the target index and the register offset
  assign tgt_idx = req_addr[`CFG_TGT_MSB:`CFG_TGT_LSB];
  assign off_nxt = cfg_off_t'(req_addr[`CFG_OFF_MSB:`CFG_OFF_LSB]);

  // indices at or above the target count land on nothing and become a miss
  assign tgt_hit = (int'(tgt_idx) < `CFG_NUM_TGTS);

  // the write level only matters while req_valid is high
  assign op_nxt = req_write ? CFG_WRITE : CFG_READ;

  // build the one-hot select, at most one bit can match the index
  always_comb begin
    sel_nxt = '0;
    for (int t = 0; t < `CFG_NUM_TGTS; t++) begin
      if (req_valid && (tgt_idx == TGT_IDX_W'(t))) begin
        sel_nxt[t] = 1'b1;
      end
    end
  end

  // registered one-hot select, all bits low in a cycle after no valid request
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      req.sel <= '0;
    end else begin
      req.sel <= sel_nxt;
    end
  end

  // request payload only follows a valid strobe
  // targets ignore it unless their sel bit is set in the same cycle
  always_ff @(posedge clk) begin
    if (req_valid) begin
      req.op    <= op_nxt;
      req.off   <= off_nxt;
      req.wdata <= req_wdata;
    end
  end

  // a miss runs through two stages so it reaches the reducer
  // in the same cycle a target ack would have arrived
  // stage one lines up with sel, stage two lines up with the bank ack
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      miss_q1 <= 1'b0;
      miss    <= 1'b0;
    end else begin
      miss_q1 <= req_valid && !tgt_hit;
      miss    <= miss_q1;
    end
  end

endmodule : cfg_req_ctrl

`default_nettype wire

/* logic/cfg_req_if.sv */
// decoded request bus from the control block to every register-bank target
`default_nettype none
`timescale 1ns/1ps

`include "cfg_params.svh"

interface cfg_req_if;
  import cfg_pkg::*;

  // one-hot select strobe, bit i belongs to target i
  logic [`CFG_NUM_TGTS-1:0] sel;
  // access type and register offset, only meaningful while a sel bit is high
  cfg_op_e                  op;
  cfg_off_t                 off;
  // write payload, ignored by targets on reads
  logic [`CFG_DATA_W-1:0]   wdata;

  // the control block drives everything
  modport ctrl (
    output sel,
    output op,
    output off,
    output wdata
  );

  // every target only listens and picks out its own sel bit
  modport target (
    input sel,
    input op,
    input off,
    input wdata
  );

endinterface : cfg_req_if

`default_nettype wire

/* logic/cfg_rsp_reduce.sv */
// response reducer, folds per-target acks and the miss flag into one registered response
`default_nettype none
`timescale 1ns/1ps

`include "cfg_params.svh"

module cfg_rsp_reduce #(
  parameter int NUM_TGTS = `CFG_NUM_TGTS
) (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic [NUM_TGTS-1:0]             in_ack,
  input  logic [NUM_TGTS-1:0]             in_err,
  input  logic [NUM_TGTS*`CFG_DATA_W-1:0] in_rdata,
  input  logic                            miss,
  output logic                            ack,
  output logic                            err,
  output logic [`CFG_DATA_W-1:0]          rdata
);

  localparam int IDX_W = (NUM_TGTS > 1) ? $clog2(NUM_TGTS) : 1;

  logic [IDX_W-1:0]       enc;
  logic                   any_ack;
  logic                   err_nxt;
  logic [`CFG_DATA_W-1:0] rdata_nxt;

  // lowest index wins, the loop walks downward so the last hit is the lowest lane
  always_comb begin
    any_ack = 1'b0;
    enc     = '0;
    for (int i = NUM_TGTS - 1; i >= 0; i--) begin
      if (in_ack[i]) begin
        any_ack = 1'b1;
        enc     = IDX_W'(i);
      end
    end
  end

  // err and data hold between responses, only a new ack or a miss moves them
  always_comb begin
    err_nxt   = err;
    rdata_nxt = rdata;
    if (any_ack) begin
      err_nxt   = in_err[enc];
      rdata_nxt = in_rdata[enc*`CFG_DATA_W +: `CFG_DATA_W];
    end else if (miss) begin
      // nobody owns the address, so the fabric answers with an error itself
      err_nxt   = 1'b1;
      rdata_nxt = '0;
    end
  end

  // registered response, ack pulses for one cycle per request
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ack   <= 1'b0;
      err   <= 1'b0;
      rdata <= '0;
    end else begin
      ack   <= any_ack | miss;
      err   <= err_nxt;
      rdata <= rdata_nxt;
    end
  end

endmodule : cfg_rsp_reduce

`default_nettype wire

/* test/cfg_fabric_tb.sv */
// directed testbench for the configuration fabric, checks responses against a register model
`default_nettype none
`timescale 1ns/1ps

`include "cfg_params.svh"

module cfg_fabric_tb;

  localparam int CLK_PERIOD = 40;
  localparam int LATENCY    = 3;
  // the five tests need a few hundred cycles including pipeline drains
  localparam int MAX_CYCLES = 2000;

  logic                   clk;
  logic                   rst_n;
  logic                   req_valid;
  logic                   req_write;
  logic [`CFG_ADDR_W-1:0] req_addr;
  logic [`CFG_DATA_W-1:0] req_wdata;
  logic                   rsp_ack;
  logic                   rsp_err;
  logic [`CFG_DATA_W-1:0] rsp_rdata;

  // reference copy of every register, offset 0 stays unused
  logic [`CFG_DATA_W-1:0] model [`CFG_NUM_TGTS][`CFG_REGS_PER_TGT];

  // outstanding responses in issue order, with the cycle each one is due
  int                     due_q      [$];
  logic                   exp_err_q  [$];
  logic [`CFG_DATA_W-1:0] exp_data_q [$];

  int                     cyc = 0;
  int                     err_count;
  int                     check_count;
  logic                   mon_on;
  logic                   last_err;
  logic [`CFG_DATA_W-1:0] last_rdata;
  logic [31:0]            seed;

  cfg_fabric_top u_cfg_fabric_top (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_valid (req_valid),
    .req_write (req_write),
    .req_addr  (req_addr),
    .req_wdata (req_wdata),
    .rsp_ack   (rsp_ack),
    .rsp_err   (rsp_err),
    .rsp_rdata (rsp_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  // a run that never drains its queue ends here
  initial begin
    while (cyc < MAX_CYCLES) @(posedge clk);
    $display("ERROR: run hung, cycle limit of %0d reached", MAX_CYCLES);
    $display("SIMULATION FAILED");
    $finish;
  end

  // linear congruential generator for data, offsets and stream requests
  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic logic [`CFG_ADDR_W-1:0] addr_of(input int tgt, input int off);
    return `CFG_ADDR_W'((tgt << `CFG_TGT_LSB) | off);
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    check_count++;
    if (got !== exp) begin
      $display("FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
      err_count++;
    end
  endtask

  // outputs are sampled on the falling edge, halfway between drive points
  always @(negedge clk) begin
    if (mon_on) begin
      // a request whose due cycle has passed without an ack is lost
      if (due_q.size() > 0 && due_q[0] < cyc) begin
        $display("ERROR: no response arrived for the request due in cycle %0d", due_q[0]);
        err_count++;
        void'(due_q.pop_front());
        void'(exp_err_q.pop_front());
        void'(exp_data_q.pop_front());
      end
      if (rsp_ack) begin
        if (due_q.size() == 0) begin
          $display("ERROR: response ack arrived with no request outstanding");
          err_count++;
        end else begin
          check("rsp_ack_cycle", cyc, due_q.pop_front());
          check("rsp_err", rsp_err, exp_err_q.pop_front());
          check("rsp_rdata", rsp_rdata, exp_data_q.pop_front());
        end
        last_err   = rsp_err;
        last_rdata = rsp_rdata;
      end else begin
        // between acks the response registers must not move
        check("rsp_err", rsp_err, last_err);
        check("rsp_rdata", rsp_rdata, last_rdata);
      end
    end
  end

  // predicts the response, updates the model and drives one request for one cycle
  task automatic issue(input logic wr, input logic [`CFG_ADDR_W-1:0] addr,
                       input logic [`CFG_DATA_W-1:0] wdata);
    int                     tgt;
    int                     off;
    logic                   e;
    logic [`CFG_DATA_W-1:0] d;
    tgt = int'(addr[`CFG_TGT_MSB:`CFG_TGT_LSB]);
    off = int'(addr[`CFG_OFF_MSB:`CFG_OFF_LSB]);
    e   = 1'b0;
    d   = '0;
    if (tgt >= `CFG_NUM_TGTS) begin
      e = 1'b1;
    end else if (wr) begin
      // the identity word refuses writes and the registers stay as they are
      if (off == 0) e = 1'b1;
      else model[tgt][off] = wdata;
    end else if (off == 0) begin
      d = {`CFG_ID_SIG, 8'(tgt)};
    end else begin
      d = model[tgt][off];
    end
    @(posedge clk);
    #1;
    req_valid = 1'b1;
    req_write = wr;
    req_addr  = addr;
    req_wdata = wdata;
    due_q.push_back(cyc + LATENCY);
    exp_err_q.push_back(e);
    exp_data_q.push_back(d);
  endtask

  // ends a burst and waits until every response has come back
  task automatic drain();
    @(posedge clk);
    #1;
    req_valid = 1'b0;
    req_write = 1'b0;
    while (due_q.size() > 0) @(negedge clk);
  endtask

  task automatic report_test(input string name, input int start_errs);
    if (err_count == start_errs) $display("test %s: ok", name);
    else $display("test %s: %0d errors", name, err_count - start_errs);
  endtask

  task automatic reset_values();
    int start;
    start = err_count;
    check("rsp_ack", rsp_ack, 1'b0);
    check("rsp_err", rsp_err, 1'b0);
    check("rsp_rdata", rsp_rdata, '0);
    for (int t = 0; t < `CFG_NUM_TGTS; t++) issue(1'b0, addr_of(t, 0), '0);
    drain();
    report_test("reset_state", start);
  endtask

  task automatic write_read_back();
    int start;
    start = err_count;
    for (int t = 0; t < `CFG_NUM_TGTS; t++) begin
      for (int o = 1; o < `CFG_REGS_PER_TGT; o++) issue(1'b1, addr_of(t, o), next_rand());
    end
    for (int t = 0; t < `CFG_NUM_TGTS; t++) begin
      for (int o = 1; o < `CFG_REGS_PER_TGT; o++) issue(1'b0, addr_of(t, o), '0);
    end
    drain();
    report_test("write_read", start);
  endtask

  task automatic identity_write_refused();
    int start;
    start = err_count;
    for (int t = 0; t < `CFG_NUM_TGTS; t++) begin
      issue(1'b1, addr_of(t, 0), next_rand());
      issue(1'b0, addr_of(t, 0), '0);
    end
    drain();
    report_test("read_only", start);
  endtask

  task automatic unmapped_access();
    int start;
    start = err_count;
    // every index past the last target, one read and one write each
    for (int t = `CFG_NUM_TGTS; t < 32; t++) begin
      issue(1'b0, addr_of(t, int'(next_rand() & 32'h7)), '0);
      issue(1'b1, addr_of(t, int'(next_rand() & 32'h7)), next_rand());
    end
    // nothing may have leaked into a real target
    for (int t = 0; t < `CFG_NUM_TGTS; t++) begin
      for (int o = 1; o < `CFG_REGS_PER_TGT; o++) issue(1'b0, addr_of(t, o), '0);
    end
    drain();
    report_test("addr_miss", start);
  endtask

  task automatic back_to_back_stream();
    int          start;
    logic [31:0] r;
    start = err_count;
    // index range 0 to 7 mixes real targets with misses
    // the top bit picks read or write, low LCG bits would repeat every other draw
    for (int n = 0; n < 40; n++) begin
      r = next_rand();
      issue(r[31], addr_of(int'(r[10:8]), int'(r[14:12])), next_rand());
    end
    drain();
    report_test("stream", start);
  endtask

  initial begin
    rst_n       = 1'b0;
    req_valid   = 1'b0;
    req_write   = 1'b0;
    req_addr    = '0;
    req_wdata   = '0;
    mon_on      = 1'b0;
    last_err    = 1'b0;
    last_rdata  = '0;
    seed        = 32'hdd38_1aaf;
    err_count   = 0;
    check_count = 0;
    for (int t = 0; t < `CFG_NUM_TGTS; t++) begin
      for (int o = 0; o < `CFG_REGS_PER_TGT; o++) model[t][o] = '0;
    end
    repeat (3) @(posedge clk);
    #1;
    rst_n  = 1'b1;
    mon_on = 1'b1;
    reset_values();
    write_read_back();
    identity_write_refused();
    unmapped_access();
    back_to_back_stream();
    $display("tests run: 5, checks: %0d, errors: %0d", check_count, err_count);
    if (err_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule : cfg_fabric_tb

`default_nettype wire
